/* logic/eth_pkg.sv */
`default_nettype none

package eth_pkg;

    // Destination MAC, source MAC, EtherType
    localparam int ETH_HDR_BYTES = 14;

    localparam logic [47:0] ETH_BCAST_MAC = 48'hFFFF_FFFF_FFFF;

    localparam logic [15:0] ETHERTYPE_IPV4 = 16'h0800;

endpackage

`default_nettype wire

/* logic/ip_pkg.sv */
`default_nettype none

package ip_pkg;

    localparam int IP_HDR_BYTES = 20; // No options

    localparam logic [3:0] IP_VERSION = 4'd4;
    localparam logic [3:0] IP_IHL_MIN = 4'd5;

    typedef struct packed {
        logic [47:0] eth_src_mac;
        logic [5:0]  dscp;
        logic [1:0]  ecn;
        logic [15:0] length;
        logic [15:0] identification;
        logic [2:0]  flags;
        logic [12:0] fragment_offset;
        logic [7:0]  ttl;
        logic [7:0]  protocol;
        logic [15:0] header_checksum;
        logic [31:0] source_ip;
        logic [31:0] dest_ip;
    } ip_hdr_t;

endpackage

`default_nettype wire

/* logic/eth_hdr_rx.sv */
`default_nettype none

module eth_hdr_rx (
    input  wire         clk,
    input  wire         rst_n,
    input  wire  [47:0] local_mac,

    input  wire  [7:0]  s_axis_tdata,
    input  wire         s_axis_tvalid,
    output logic        s_axis_tready,
    input  wire         s_axis_tlast,
    input  wire         s_axis_tuser,

    output logic [47:0] eth_src_mac,
    output logic [7:0]  m_tdata,
    output logic        m_tvalid,
    input  wire         m_tready,
    output logic        m_tlast,
    output logic        m_tuser
);

typedef enum logic [1:0] {ST_HDR, ST_PASS, ST_DROP} state_t;

state_t       state;
logic [3:0]   byte_cnt;
logic [103:0] hdr_sr;     // First 13 header bytes
logic [111:0] hdr_next;
logic         s_fire;
logic         hdr_end;
logic         frame_ok;

assign s_fire   = s_axis_tvalid && s_axis_tready;
assign hdr_next = {hdr_sr, s_axis_tdata};
assign hdr_end  = s_fire && state == ST_HDR &&
                  byte_cnt == 4'(eth_pkg::ETH_HDR_BYTES - 1);

// Unicast to us or broadcast, IPv4 only
assign frame_ok = (hdr_next[111:64] == local_mac ||
                   hdr_next[111:64] == eth_pkg::ETH_BCAST_MAC) &&
                  hdr_next[15:0] == eth_pkg::ETHERTYPE_IPV4;

// Also holds off the next header while the last byte is still pending,
// so eth_src_mac cannot move under the consumer
assign s_axis_tready = (state == ST_DROP) || !m_tvalid || m_tready;

always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        state    <= ST_HDR;
        byte_cnt <= '0;
        m_tvalid <= 1'b0;
    end else begin
        if (m_tready) begin
            m_tvalid <= 1'b0;
        end
        if (s_fire) begin
            case (state)
                ST_HDR: begin
                    if (s_axis_tlast) begin
                        byte_cnt <= '0; // Runt frame
                    end else if (hdr_end) begin
                        byte_cnt <= '0;
                        state    <= frame_ok ? ST_PASS : ST_DROP;
                    end else begin
                        byte_cnt <= byte_cnt + 4'd1;
                    end
                end
                ST_PASS: begin
                    m_tvalid <= 1'b1;
                    if (s_axis_tlast) begin
                        state <= ST_HDR;
                    end
                end
                default: begin
                    if (s_axis_tlast) begin
                        state <= ST_HDR;
                    end
                end
            endcase
        end
    end
end

always_ff @(posedge clk) begin
    if (s_fire && state == ST_HDR) begin
        hdr_sr <= hdr_next[103:0];
    end
    if (hdr_end) begin
        eth_src_mac <= hdr_next[63:16];
    end
    if (s_fire && state == ST_PASS) begin
        m_tdata <= s_axis_tdata;
        m_tlast <= s_axis_tlast;
        m_tuser <= s_axis_tlast && s_axis_tuser;
    end
end

endmodule

`default_nettype wire

/* logic/ip_hdr_check.sv */
`default_nettype none

module ip_hdr_check (
    input  wire             clk,
    input  wire             rst_n,
    input  wire  [31:0]     local_ip,

    input  wire  [7:0]      eth_payload_tdata,
    input  wire             eth_payload_tvalid,
    output logic            eth_payload_tready,
    input  wire             eth_payload_tlast,
    input  wire             eth_payload_tuser,
    input  wire  [47:0]     eth_src_mac,

    output ip_pkg::ip_hdr_t hdr_bundle,
    output logic            hdr_valid,
    input  wire             hdr_ready,

    output logic [7:0]      ip_payload_tdata,
    output logic            ip_payload_tvalid,
    input  wire             ip_payload_tready,
    output logic            ip_payload_tlast,
    output logic            ip_payload_tuser,

    output logic            error_invalid_header,
    output logic            error_invalid_checksum,
    output logic            error_early_termination
);

typedef enum logic [1:0] {ST_HDR, ST_WAIT, ST_PAYLOAD, ST_SKIP} state_t;

state_t       state;
logic [4:0]   byte_cnt;
logic [151:0] hdr_sr;
logic [159:0] hdr_next;   // Byte 0 in the top bits
logic [15:0]  ip_len;
logic [19:0]  csum_acc;
logic [19:0]  csum_next;
logic [16:0]  fold1;
logic [15:0]  fold2;
logic [15:0]  rem_len;
logic         tail_done;  // tlast already seen on the last header byte
logic         in_fire;
logic         hdr_end;
logic         hdr_bad;
logic         csum_bad;

assign in_fire  = eth_payload_tvalid && eth_payload_tready;
assign hdr_next = {hdr_sr, eth_payload_tdata};
assign ip_len   = hdr_next[143:128];
assign hdr_end  = in_fire && state == ST_HDR &&
                  byte_cnt == 5'(ip_pkg::IP_HDR_BYTES - 1);

// Add a 16-bit word on every odd byte
assign csum_next = byte_cnt[0] ? csum_acc + 20'({hdr_sr[7:0], eth_payload_tdata}) : csum_acc;
assign fold1     = 17'(csum_next[15:0]) + 17'(csum_next[19:16]);
assign fold2     = fold1[15:0] + 16'(fold1[16]);
assign csum_bad  = fold2 != 16'hFFFF;

assign hdr_bad = hdr_next[159:156] != ip_pkg::IP_VERSION ||
                 hdr_next[155:152] != ip_pkg::IP_IHL_MIN ||
                 hdr_next[31:0] != local_ip ||
                 ip_len < 16'(ip_pkg::IP_HDR_BYTES); // Length shorter than the header itself

// Stalled while the header waits to be taken
assign eth_payload_tready = (state == ST_HDR) || (state == ST_SKIP) ||
                            (state == ST_PAYLOAD && (!ip_payload_tvalid || ip_payload_tready));

always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        state                   <= ST_HDR;
        byte_cnt                <= '0;
        csum_acc                <= '0;
        rem_len                 <= '0;
        tail_done               <= 1'b0;
        hdr_valid               <= 1'b0;
        ip_payload_tvalid       <= 1'b0;
        error_invalid_header    <= 1'b0;
        error_invalid_checksum  <= 1'b0;
        error_early_termination <= 1'b0;
    end else begin
        error_invalid_header    <= 1'b0;
        error_invalid_checksum  <= 1'b0;
        error_early_termination <= 1'b0;
        if (hdr_ready) begin
            hdr_valid <= 1'b0;
        end
        if (ip_payload_tready) begin
            ip_payload_tvalid <= 1'b0;
        end
        case (state)
            ST_HDR: begin
                if (in_fire) begin
                    if (hdr_end || eth_payload_tlast) begin
                        byte_cnt <= '0;
                        csum_acc <= '0;
                    end else begin
                        byte_cnt <= byte_cnt + 5'd1;
                        csum_acc <= csum_next;
                    end
                    if (hdr_end) begin
                        tail_done <= eth_payload_tlast;
                        rem_len   <= ip_len - 16'(ip_pkg::IP_HDR_BYTES);
                        if (hdr_bad) begin
                            error_invalid_header <= 1'b1;
                            state <= eth_payload_tlast ? ST_HDR : ST_SKIP;
                        end else if (csum_bad) begin
                            error_invalid_checksum <= 1'b1;
                            state <= eth_payload_tlast ? ST_HDR : ST_SKIP;
                        end else if (eth_payload_tlast &&
                                     ip_len != 16'(ip_pkg::IP_HDR_BYTES)) begin
                            error_early_termination <= 1'b1; // Payload missing entirely
                        end else begin
                            hdr_valid <= 1'b1;
                            state     <= ST_WAIT;
                        end
                    end else if (eth_payload_tlast) begin
                        error_early_termination <= 1'b1; // Truncated header
                    end
                end
            end
            ST_WAIT: begin
                if (hdr_ready) begin
                    if (tail_done) begin
                        state <= ST_HDR;
                    end else begin
                        state <= (rem_len == 16'd0) ? ST_SKIP : ST_PAYLOAD;
                    end
                end
            end
            ST_PAYLOAD: begin
                if (in_fire) begin
                    ip_payload_tvalid <= 1'b1;
                    rem_len           <= rem_len - 16'd1;
                    if (rem_len == 16'd1) begin
                        state <= eth_payload_tlast ? ST_HDR : ST_SKIP; // Trim padding
                    end else if (eth_payload_tlast) begin
                        state                   <= ST_HDR;
                        error_early_termination <= 1'b1;
                    end
                end
            end
            default: begin
                if (in_fire && eth_payload_tlast) begin
                    state <= ST_HDR;
                end
            end
        endcase
    end
end

always_ff @(posedge clk) begin
    if (in_fire && state == ST_HDR) begin
        hdr_sr <= hdr_next[151:0];
    end
    if (hdr_end) begin
        hdr_bundle.eth_src_mac     <= eth_src_mac;
        hdr_bundle.dscp            <= hdr_next[151:146];
        hdr_bundle.ecn             <= hdr_next[145:144];
        hdr_bundle.length          <= ip_len;
        hdr_bundle.identification  <= hdr_next[127:112];
        hdr_bundle.flags           <= hdr_next[111:109];
        hdr_bundle.fragment_offset <= hdr_next[108:96];
        hdr_bundle.ttl             <= hdr_next[95:88];
        hdr_bundle.protocol        <= hdr_next[87:80];
        hdr_bundle.header_checksum <= hdr_next[79:64];
        hdr_bundle.source_ip       <= hdr_next[63:32];
        hdr_bundle.dest_ip         <= hdr_next[31:0];
    end
    if (in_fire && state == ST_PAYLOAD) begin
        ip_payload_tdata <= eth_payload_tdata;
        ip_payload_tlast <= eth_payload_tlast || rem_len == 16'd1;
        // Short frame or MAC error on the final byte
        ip_payload_tuser <= eth_payload_tlast && (eth_payload_tuser || rem_len != 16'd1);
    end
end

endmodule

`default_nettype wire

/* logic/rx_skid.sv */
`default_nettype none

module rx_skid #(
    parameter type payload_t = logic [7:0]
) (
    input  wire           clk,
    input  wire           rst_n,

    input  wire payload_t in_data,
    input  wire           in_valid,
    output logic          in_ready,

    output payload_t      out_data,
    output logic          out_valid,
    input  wire           out_ready
);

payload_t spare_data;
logic     spare_valid;
logic     in_fire;
logic     main_load;

// Ready comes straight from a flop
assign in_ready  = !spare_valid;
assign in_fire   = in_valid && in_ready;
assign main_load = out_ready || !out_valid;

always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        out_valid   <= 1'b0;
        spare_valid <= 1'b0;
    end else begin
        if (main_load) begin
            if (spare_valid) begin
                out_valid   <= 1'b1;
                spare_valid <= 1'b0; // Drain spare first
            end else begin
                out_valid <= in_fire;
            end
        end else if (in_fire) begin
            spare_valid <= 1'b1;
        end
    end
end

always_ff @(posedge clk) begin
    if (main_load) begin
        out_data <= spare_valid ? spare_data : in_data;
    end
    if (in_fire && !main_load) begin
        spare_data <= in_data;
    end
end

endmodule

`default_nettype wire

/* logic/ip_rx_top.sv */
`default_nettype none

module ip_rx_top (
    input  wire         clk,
    input  wire         rst_n,
    input  wire  [$bits(eth_pkg::ETH_BCAST_MAC)-1:0] local_mac,
    input  wire  [31:0] local_ip,

    input  wire  [7:0]  s_axis_tdata,
    input  wire         s_axis_tvalid,
    output wire         s_axis_tready,
    input  wire         s_axis_tlast,
    input  wire         s_axis_tuser,

    output wire         m_ip_hdr_valid,
    input  wire         m_ip_hdr_ready,
    output wire  [$bits(eth_pkg::ETH_BCAST_MAC)-1:0] m_ip_eth_src_mac,
    output wire  [5:0]  m_ip_dscp,
    output wire  [1:0]  m_ip_ecn,
    output wire  [15:0] m_ip_length,
    output wire  [15:0] m_ip_identification,
    output wire  [2:0]  m_ip_flags,
    output wire  [12:0] m_ip_fragment_offset,
    output wire  [7:0]  m_ip_ttl,
    output wire  [7:0]  m_ip_protocol,
    output wire  [15:0] m_ip_header_checksum,
    output wire  [31:0] m_ip_source_ip,
    output wire  [31:0] m_ip_dest_ip,

    output wire  [7:0]  m_ip_payload_axis_tdata,
    output wire         m_ip_payload_axis_tvalid,
    input  wire         m_ip_payload_axis_tready,
    output wire         m_ip_payload_axis_tlast,
    output wire         m_ip_payload_axis_tuser,

    output wire         error_invalid_header,
    output wire         error_invalid_checksum,
    output wire         error_early_termination
);

typedef struct packed {
    logic [7:0] tdata;
    logic       tlast;
    logic       tuser;
} axis_byte_t;

wire [7:0]  eth_payload_tdata;
wire        eth_payload_tvalid;
wire        eth_payload_tready;
wire        eth_payload_tlast;
wire        eth_payload_tuser;
wire [47:0] eth_src_mac;

ip_pkg::ip_hdr_t hdr_bundle;
ip_pkg::ip_hdr_t hdr_out;
wire             hdr_valid;
wire             hdr_ready;

wire [7:0]  ip_payload_tdata;
wire        ip_payload_tvalid;
wire        ip_payload_tready;
wire        ip_payload_tlast;
wire        ip_payload_tuser;
axis_byte_t payload_in;
axis_byte_t payload_out;

eth_hdr_rx u_eth_hdr_rx (
    .clk(clk),
    .rst_n(rst_n),
    .local_mac(local_mac),
    .s_axis_tdata(s_axis_tdata),
    .s_axis_tvalid(s_axis_tvalid),
    .s_axis_tready(s_axis_tready),
    .s_axis_tlast(s_axis_tlast),
    .s_axis_tuser(s_axis_tuser),
    .eth_src_mac(eth_src_mac),
    .m_tdata(eth_payload_tdata),
    .m_tvalid(eth_payload_tvalid),
    .m_tready(eth_payload_tready),
    .m_tlast(eth_payload_tlast),
    .m_tuser(eth_payload_tuser)
);

ip_hdr_check u_ip_hdr_check (
    .clk(clk),
    .rst_n(rst_n),
    .local_ip(local_ip),
    .eth_payload_tdata(eth_payload_tdata),
    .eth_payload_tvalid(eth_payload_tvalid),
    .eth_payload_tready(eth_payload_tready),
    .eth_payload_tlast(eth_payload_tlast),
    .eth_payload_tuser(eth_payload_tuser),
    .eth_src_mac(eth_src_mac),
    .hdr_bundle(hdr_bundle),
    .hdr_valid(hdr_valid),
    .hdr_ready(hdr_ready),
    .ip_payload_tdata(ip_payload_tdata),
    .ip_payload_tvalid(ip_payload_tvalid),
    .ip_payload_tready(ip_payload_tready),
    .ip_payload_tlast(ip_payload_tlast),
    .ip_payload_tuser(ip_payload_tuser),
    .error_invalid_header(error_invalid_header),
    .error_invalid_checksum(error_invalid_checksum),
    .error_early_termination(error_early_termination)
);

rx_skid #(.payload_t(ip_pkg::ip_hdr_t)) u_hdr_slice (
    .clk(clk),
    .rst_n(rst_n),
    .in_data(hdr_bundle),
    .in_valid(hdr_valid),
    .in_ready(hdr_ready),
    .out_data(hdr_out),
    .out_valid(m_ip_hdr_valid),
    .out_ready(m_ip_hdr_ready)
);

assign payload_in = '{tdata: ip_payload_tdata, tlast: ip_payload_tlast, tuser: ip_payload_tuser};

rx_skid #(.payload_t(axis_byte_t)) u_payload_slice (
    .clk(clk),
    .rst_n(rst_n),
    .in_data(payload_in),
    .in_valid(ip_payload_tvalid),
    .in_ready(ip_payload_tready),
    .out_data(payload_out),
    .out_valid(m_ip_payload_axis_tvalid),
    .out_ready(m_ip_payload_axis_tready)
);

assign m_ip_payload_axis_tdata = payload_out.tdata;
assign m_ip_payload_axis_tlast = payload_out.tlast;
assign m_ip_payload_axis_tuser = payload_out.tuser;

assign m_ip_eth_src_mac     = hdr_out.eth_src_mac;
assign m_ip_dscp            = hdr_out.dscp;
assign m_ip_ecn             = hdr_out.ecn;
assign m_ip_length          = hdr_out.length;
assign m_ip_identification  = hdr_out.identification;
assign m_ip_flags           = hdr_out.flags;
assign m_ip_fragment_offset = hdr_out.fragment_offset;
assign m_ip_ttl             = hdr_out.ttl;
assign m_ip_protocol        = hdr_out.protocol;
assign m_ip_header_checksum = hdr_out.header_checksum;
assign m_ip_source_ip       = hdr_out.source_ip;
assign m_ip_dest_ip         = hdr_out.dest_ip;

endmodule

`default_nettype wire

/* verif/ip_rx_chk.sv */
`default_nettype none

module ip_rx_chk (
    input wire             clk,
    input wire             rst_n,
    input wire             s_axis_tvalid,
    input wire             s_axis_tready,
    input wire  [7:0]      s_axis_tdata,
    input wire             s_axis_tlast,
    input wire             s_axis_tuser,
    input wire             m_ip_hdr_valid,
    input wire             m_ip_hdr_ready,
    input ip_pkg::ip_hdr_t hdr_out,
    input wire             pay_valid,
    input wire             pay_ready,
    input wire  [7:0]      pay_data,
    input wire             pay_last,
    input wire             pay_user,
    input wire             hdr_valid,
    input wire             err_hdr,
    input wire             err_csum,
    input wire             err_early
);

int fail_cnt = 0;

a_in_hold: assert property (@(posedge clk) disable iff (!rst_n)
    s_axis_tvalid && !s_axis_tready |=>
        s_axis_tvalid && $stable({s_axis_tdata, s_axis_tlast, s_axis_tuser}))
    else begin
        fail_cnt++;
        $error("input stream changed while stalled");
    end

a_hdr_hold: assert property (@(posedge clk) disable iff (!rst_n)
    m_ip_hdr_valid && !m_ip_hdr_ready |=> m_ip_hdr_valid && $stable(hdr_out))
    else begin
        fail_cnt++;
        $error("header output changed while stalled");
    end

a_pay_hold: assert property (@(posedge clk) disable iff (!rst_n)
    pay_valid && !pay_ready |=> pay_valid && $stable({pay_data, pay_last, pay_user}))
    else begin
        fail_cnt++;
        $error("payload output changed while stalled");
    end

// Header is never offered in the cycle an error fires
a_no_hdr_on_err: assert property (@(posedge clk) disable iff (!rst_n)
    (err_hdr || err_csum || err_early) |-> !hdr_valid)
    else begin
        fail_cnt++;
        $error("header valid together with an error pulse");
    end

a_one_err: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0({err_hdr, err_csum, err_early}))
    else begin
        fail_cnt++;
        $error("more than one error pulse in a cycle");
    end

endmodule

bind ip_rx_top ip_rx_chk u_chk (
    .clk(clk), .rst_n(rst_n),
    .s_axis_tvalid(s_axis_tvalid), .s_axis_tready(s_axis_tready),
    .s_axis_tdata(s_axis_tdata), .s_axis_tlast(s_axis_tlast),
    .s_axis_tuser(s_axis_tuser),
    .m_ip_hdr_valid(m_ip_hdr_valid), .m_ip_hdr_ready(m_ip_hdr_ready), .hdr_out(hdr_out),
    .pay_valid(m_ip_payload_axis_tvalid), .pay_ready(m_ip_payload_axis_tready),
    .pay_data(m_ip_payload_axis_tdata), .pay_last(m_ip_payload_axis_tlast),
    .pay_user(m_ip_payload_axis_tuser), .hdr_valid(hdr_valid),
    .err_hdr(error_invalid_header), .err_csum(error_invalid_checksum),
    .err_early(error_early_termination)
);

`default_nettype wire

/* verif/ip_rx_tb.sv */
`default_nettype none

module ip_rx_tb;

localparam int N_FRAMES = 10;
localparam int TIMEOUT = 3000;
localparam int NO_TRUNC = 9999;
localparam logic [47:0] MY_MAC = 48'h02_00_00_00_00_01;
localparam logic [47:0] OTHER_MAC = 48'h02_00_00_00_00_99;
localparam logic [47:0] BCAST_MAC = 48'hFFFF_FFFF_FFFF;
localparam logic [31:0] MY_IP = 32'hC0A8_0001;
localparam logic [31:0] OTHER_IP = 32'hC0A8_0063;
localparam int OUT_OK = 0;
localparam int OUT_DROP = 1;
localparam int E_HDR = 2;
localparam int E_CSUM = 3;
localparam int E_EARLY = 4;

// MAC choice is 0 for local, 1 for broadcast and 2 for other
int          t_mac    [N_FRAMES] = '{0, 1, 2, 0, 0, 0, 0, 0, 0, 0};
logic [15:0] t_etype  [N_FRAMES] = '{16'h0800, 16'h0800, 16'h0800, 16'h0806, 16'h0800,
                                     16'h0800, 16'h0800, 16'h0800, 16'h0800, 16'h0800};
logic [31:0] t_ip     [N_FRAMES] = '{MY_IP, MY_IP, MY_IP, MY_IP, MY_IP,
                                     MY_IP, OTHER_IP, MY_IP, MY_IP, MY_IP};
bit          t_bad    [N_FRAMES] = '{0, 0, 0, 0, 1, 0, 0, 0, 0, 0};
logic [3:0]  t_ver    [N_FRAMES] = '{4, 4, 4, 4, 4, 6, 4, 4, 4, 4};
int          t_len    [N_FRAMES] = '{12, 5, 10, 10, 10, 10, 10, 30, 8, 1};
int          t_pad    [N_FRAMES] = '{0, 20, 0, 0, 0, 0, 0, 0, 0, 3};
int          t_trunc  [N_FRAMES] = '{NO_TRUNC, NO_TRUNC, NO_TRUNC, NO_TRUNC, NO_TRUNC,
                                     NO_TRUNC, NO_TRUNC, 10, NO_TRUNC, NO_TRUNC};
bit          t_macerr [N_FRAMES] = '{0, 0, 0, 0, 0, 0, 0, 0, 1, 0};
int          t_out    [N_FRAMES] = '{OUT_OK, OUT_OK, OUT_DROP, OUT_DROP, E_CSUM,
                                     E_HDR, E_HDR, E_EARLY, OUT_OK, OUT_OK};

logic        clk = 1'b0;
logic        rst_n;
logic [7:0]  s_axis_tdata;
logic        s_axis_tvalid;
wire         s_axis_tready;
logic        s_axis_tlast;
logic        s_axis_tuser;
logic        m_hdr_ready = 1'b1;
logic        m_pay_ready = 1'b1;
logic        bp_on = 1'b0;
wire         m_ip_hdr_valid;
wire  [47:0] m_ip_eth_src_mac;
wire  [5:0]  m_ip_dscp;
wire  [1:0]  m_ip_ecn;
wire  [15:0] m_ip_length;
wire  [15:0] m_ip_identification;
wire  [2:0]  m_ip_flags;
wire  [12:0] m_ip_fragment_offset;
wire  [7:0]  m_ip_ttl;
wire  [7:0]  m_ip_protocol;
wire  [15:0] m_ip_header_checksum;
wire  [31:0] m_ip_source_ip;
wire  [31:0] m_ip_dest_ip;
wire  [7:0]  pay_tdata;
wire         pay_tvalid;
wire         pay_tlast;
wire         pay_tuser;
wire         error_invalid_header;
wire         error_invalid_checksum;
wire         error_early_termination;

logic [9:0]   stim_q[$];    // {tuser, tlast, tdata}
logic [199:0] exp_hdr_q[$];
logic [199:0] obs_hdr_q[$];
logic [9:0]   exp_pay_q[$];
logic [9:0]   obs_pay_q[$];
int           exp_err_q[$];
int           obs_err_q[$];
int           errors = 0;
int           timeouts = 0;

always #10 clk = !clk;

ip_rx_top u_dut (
    .clk(clk), .rst_n(rst_n), .local_mac(MY_MAC), .local_ip(MY_IP),
    .s_axis_tdata(s_axis_tdata), .s_axis_tvalid(s_axis_tvalid),
    .s_axis_tready(s_axis_tready), .s_axis_tlast(s_axis_tlast),
    .s_axis_tuser(s_axis_tuser),
    .m_ip_hdr_valid(m_ip_hdr_valid), .m_ip_hdr_ready(m_hdr_ready),
    .m_ip_eth_src_mac(m_ip_eth_src_mac), .m_ip_dscp(m_ip_dscp), .m_ip_ecn(m_ip_ecn),
    .m_ip_length(m_ip_length), .m_ip_identification(m_ip_identification),
    .m_ip_flags(m_ip_flags), .m_ip_fragment_offset(m_ip_fragment_offset),
    .m_ip_ttl(m_ip_ttl), .m_ip_protocol(m_ip_protocol),
    .m_ip_header_checksum(m_ip_header_checksum), .m_ip_source_ip(m_ip_source_ip),
    .m_ip_dest_ip(m_ip_dest_ip),
    .m_ip_payload_axis_tdata(pay_tdata), .m_ip_payload_axis_tvalid(pay_tvalid),
    .m_ip_payload_axis_tready(m_pay_ready), .m_ip_payload_axis_tlast(pay_tlast),
    .m_ip_payload_axis_tuser(pay_tuser),
    .error_invalid_header(error_invalid_header),
    .error_invalid_checksum(error_invalid_checksum),
    .error_early_termination(error_early_termination)
);

always @(negedge clk) begin
    m_hdr_ready <= bp_on ? 1'($urandom_range(1)) : 1'b1;
    m_pay_ready <= bp_on ? 1'($urandom_range(1)) : 1'b1;
end

always @(posedge clk) begin
    if (rst_n) begin
        if (m_ip_hdr_valid && m_hdr_ready) begin
            obs_hdr_q.push_back({m_ip_eth_src_mac, m_ip_dscp, m_ip_ecn, m_ip_length,
                                 m_ip_identification, m_ip_flags, m_ip_fragment_offset,
                                 m_ip_ttl, m_ip_protocol, m_ip_header_checksum,
                                 m_ip_source_ip, m_ip_dest_ip});
        end
        if (pay_tvalid && m_pay_ready) begin
            obs_pay_q.push_back({pay_tuser, pay_tlast, pay_tdata});
        end
        if (error_invalid_header) obs_err_q.push_back(E_HDR);
        if (error_invalid_checksum) obs_err_q.push_back(E_CSUM);
        if (error_early_termination) obs_err_q.push_back(E_EARLY);
    end
end

// Ones-complement sum over ten words, then inverted
function automatic logic [15:0] ip_checksum(input logic [7:0] h [20]);
    logic [31:0] sum;
    sum = 0;
    for (int k = 0; k < 20; k += 2) begin
        sum += {h[k], h[k + 1]};
    end
    sum = sum[15:0] + sum[31:16];
    sum = sum[15:0] + sum[31:16];
    return ~sum[15:0];
endfunction

task automatic build_frame(input int i);
    logic [7:0]   h [20];
    logic [7:0]   f[$];
    logic [47:0]  dst;
    logic [47:0]  src;
    logic [8 * eth_pkg::ETH_HDR_BYTES - 1:0] eth_hdr;
    logic [15:0]  csum;
    logic [7:0]   b;
    int           n_ip;
    bit           delivered;
    bit           short;
    dst = t_mac[i] == 0 ? MY_MAC : (t_mac[i] == 1 ? BCAST_MAC : OTHER_MAC);
    src = {16'h0200, $urandom()};
    delivered = t_out[i] == OUT_OK || t_out[i] == E_EARLY;
    short = t_trunc[i] < t_len[i];
    n_ip = short ? t_trunc[i] : t_len[i];
    h[0] = {t_ver[i], ip_pkg::IP_IHL_MIN};
    h[1] = 8'($urandom());
    {h[2], h[3]} = 16'(ip_pkg::IP_HDR_BYTES + t_len[i]);
    {h[4], h[5], h[6], h[7]} = $urandom(); // Id, flags, fragment offset
    h[8] = 8'd64;
    h[9] = 8'd17;
    {h[10], h[11]} = 16'h0000;
    {h[12], h[13], h[14], h[15]} = $urandom();
    {h[16], h[17], h[18], h[19]} = t_ip[i];
    csum = ip_checksum(h) ^ (t_bad[i] ? 16'h0101 : 16'h0000);
    {h[10], h[11]} = csum;
    eth_hdr = {dst, src, t_etype[i]};
    for (int k = 0; k < eth_pkg::ETH_HDR_BYTES; k++) begin
        f.push_back(eth_hdr[8 * (eth_pkg::ETH_HDR_BYTES - 1 - k) +: 8]);
    end
    for (int k = 0; k < 20; k++) f.push_back(h[k]);
    for (int k = 0; k < n_ip; k++) begin
        b = 8'($urandom());
        f.push_back(b);
        if (delivered) begin
            exp_pay_q.push_back({k == n_ip - 1 && (short || t_macerr[i]),
                                 k == n_ip - 1, b});
        end
    end
    if (!short) begin
        for (int k = 0; k < t_pad[i]; k++) f.push_back(8'($urandom()));
    end
    foreach (f[k]) begin
        stim_q.push_back({k == f.size() - 1 && t_macerr[i], k == f.size() - 1, f[k]});
    end
    if (delivered) begin
        exp_hdr_q.push_back({src, h[1], h[2], h[3], h[4], h[5], h[6], h[7], h[8], h[9],
                             csum, h[12], h[13], h[14], h[15], t_ip[i]});
    end
    if (t_out[i] >= E_HDR) exp_err_q.push_back(t_out[i]);
endtask

task automatic drive_stream();
    int t;
    foreach (stim_q[k]) begin
        @(negedge clk);
        if ($urandom_range(3) == 0) begin
            s_axis_tvalid = 1'b0; // Gap in valid
            @(negedge clk);
        end
        s_axis_tvalid = 1'b1;
        {s_axis_tuser, s_axis_tlast, s_axis_tdata} = stim_q[k];
        t = 0;
        @(posedge clk);
        while (!s_axis_tready && t < TIMEOUT) begin
            t++;
            @(posedge clk);
        end
        if (t >= TIMEOUT) begin
            timeouts++;
            $display("Timed out: input stream never accepted byte %0d", k);
            break;
        end
    end
    @(negedge clk);
    s_axis_tvalid = 1'b0;
    s_axis_tlast = 1'b0;
endtask

task automatic wait_drain();
    int t;
    t = 0;
    while ((obs_pay_q.size() < exp_pay_q.size() || obs_hdr_q.size() < exp_hdr_q.size())
           && t < TIMEOUT) begin
        t++;
        @(posedge clk);
    end
    if (t >= TIMEOUT) begin
        timeouts++;
        $display("Timed out: outputs did not deliver the expected headers and payload");
    end
    repeat (20) @(posedge clk);
endtask

task automatic compare_queues(input int pass);
    assert (obs_hdr_q.size() == exp_hdr_q.size()) else begin
        errors++;
        $display("FAIL pass %0d header count: expected %0h got %0h", pass,
                 exp_hdr_q.size(), obs_hdr_q.size());
    end
    assert (obs_pay_q.size() == exp_pay_q.size()) else begin
        errors++;
        $display("FAIL pass %0d payload count: expected %0h got %0h", pass,
                 exp_pay_q.size(), obs_pay_q.size());
    end
    assert (obs_err_q.size() == exp_err_q.size()) else begin
        errors++;
        $display("FAIL pass %0d error pulse count: expected %0h got %0h", pass,
                 exp_err_q.size(), obs_err_q.size());
    end
    for (int k = 0; k < obs_err_q.size() && k < exp_err_q.size(); k++) begin
        assert (obs_err_q[k] == exp_err_q[k]) else begin
            errors++;
            $display("FAIL error_* pulse code #%0d: expected %0h got %0h", k,
                     exp_err_q[k], obs_err_q[k]);
        end
    end
    for (int k = 0; k < obs_hdr_q.size() && k < exp_hdr_q.size(); k++) begin
        assert (obs_hdr_q[k] == exp_hdr_q[k]) else begin
            errors++;
            $display("FAIL m_ip header fields #%0d: expected %h got %h", k,
                     exp_hdr_q[k], obs_hdr_q[k]);
        end
    end
    for (int k = 0; k < obs_pay_q.size() && k < exp_pay_q.size(); k++) begin
        assert (obs_pay_q[k] == exp_pay_q[k]) else begin
            errors++;
            $display("FAIL m_ip_payload_axis {tuser,tlast,tdata} #%0d: expected %h got %h",
                     k, exp_pay_q[k], obs_pay_q[k]);
        end
    end
endtask

initial begin
    void'($urandom(65));
    rst_n = 1'b0;
    s_axis_tdata = 8'h00;
    s_axis_tvalid = 1'b0;
    s_axis_tlast = 1'b0;
    s_axis_tuser = 1'b0;
    for (int i = 0; i < N_FRAMES; i++) build_frame(i);
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    // Pass 0 with ready held high, pass 1 under random back-pressure
    for (int pass = 0; pass < 2 && timeouts == 0; pass++) begin
        bp_on = pass == 1;
        obs_hdr_q.delete();
        obs_pay_q.delete();
        obs_err_q.delete();
        drive_stream();
        wait_drain();
        compare_queues(pass);
    end
    $display("Checks done: %0d errors, %0d timeouts, %0d assertion failures",
             errors, timeouts, u_dut.u_chk.fail_cnt);
    if (errors == 0 && timeouts == 0 && u_dut.u_chk.fail_cnt == 0) begin
        $display("Simulation PASSED");
    end else begin
        $display("Simulation FAILED");
    end
    $finish;
end

endmodule

`default_nettype wire

/* all.f */
logic/eth_pkg.sv
logic/ip_pkg.sv
logic/eth_hdr_rx.sv
logic/ip_hdr_check.sv
logic/rx_skid.sv
logic/ip_rx_top.sv
verif/ip_rx_chk.sv
verif/ip_rx_tb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module ip_rx_tb -f all.f \
    -o ip_rx_sim > build.log 2>&1 || { echo "Build failed, see build.log"; exit 1; }
./obj_dir/ip_rx_sim > sim.log 2>&1 || { cat sim.log; echo "Run aborted"; exit 1; }
cat sim.log
grep -q "Simulation FAILED" sim.log && exit 1
grep -q "Simulation PASSED" sim.log || exit 1
exit 0
